/* hdl/clock_pkg.sv */
package clock_pkg;

	// ----------------------------------------
	// operating mode and setup position
	// ----------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK,	// free running time
		MODE_SETUP,	// time frozen, inc steps wall time
		MODE_ALARM	// alarm time shown and stepped
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC,
		POS_MIN,
		POS_HR
	} pos_e;

	// ----------------------------------------
	// time values
	// ----------------------------------------
	typedef logic [5:0] field_t;

	typedef struct packed {
		field_t hr;
		field_t min;
		field_t sec;
	} hms_t;

	// wrap limits, 24h form
	localparam field_t SEC_MAX = 6'd59;
	localparam field_t MIN_MAX = 6'd59;
	localparam field_t HR_MAX = 6'd23;

	// one clk wide press strobes
	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alarm;
	} key_evt_t;

endpackage

/* hdl/disp_pkg.sv */
package disp_pkg;

	localparam int NUM_DIGITS = 6;

	// bit 6 is segment a, bit 0 is segment g
	typedef logic [6:0] seg_t;

	localparam seg_t SEG_BLANK = 7'b000_0000;

	function automatic seg_t digit_to_seg(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b111_1110;
			4'd1: return 7'b011_0000;
			4'd2: return 7'b110_1101;
			4'd3: return 7'b111_1001;
			4'd4: return 7'b011_0011;
			4'd5: return 7'b101_1011;
			4'd6: return 7'b101_1111;
			4'd7: return 7'b111_0000;
			4'd8: return 7'b111_1111;
			4'd9: return 7'b111_0011;
			default: return SEG_BLANK;	// not a decimal digit
		endcase
	endfunction

endpackage

/* hdl/tick_gen.sv */
module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			cnt <= CW'(DIV - 1);
		end else if (cnt == '0) begin
			cnt <= CW'(DIV - 1);	// reload
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign o_tick = (cnt == '0);

	// back to back strobes would mean DIV below 2
	a_div_min: assert property (@(posedge clk) disable iff (rst_n == 1'b0)
		o_tick |=> !o_tick);

endmodule

/* hdl/key_ctrl.sv */
module key_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_key_tick,
	input  logic                i_key_mode,
	input  logic                i_key_pos,
	input  logic                i_key_inc,
	input  logic                i_key_alarm,
	output clock_pkg::key_evt_t o_evt,
	output clock_pkg::mode_e    o_mode,
	output clock_pkg::pos_e     o_pos,
	output logic                o_alarm_en
);

	clock_pkg::key_evt_t key_lvl;
	clock_pkg::key_evt_t smp1;	// latest sample
	clock_pkg::key_evt_t smp2;	// sample one key tick older
	clock_pkg::key_evt_t press;

	assign key_lvl = {i_key_mode, i_key_pos, i_key_inc, i_key_alarm};

	// ----------------------------------------
	// sampling and edge detect
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			smp1 <= '0;
			smp2 <= '0;
		end else if (i_key_tick) begin
			smp1 <= key_lvl;
			smp2 <= smp1;
		end
	end

	// low then high across two samples
	assign press = i_key_tick ? (smp1 & ~smp2) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_evt <= '0;
		end else begin
			o_evt <= press;
		end
	end

	// ----------------------------------------
	// mode, position, alarm enable
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_mode <= clock_pkg::MODE_CLOCK;
		end else if (press.mode) begin
			case (o_mode)
				clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SETUP;
				clock_pkg::MODE_SETUP: o_mode <= clock_pkg::MODE_ALARM;
				default:               o_mode <= clock_pkg::MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_pos <= clock_pkg::POS_SEC;
		end else if (press.pos) begin
			case (o_pos)
				clock_pkg::POS_SEC: o_pos <= clock_pkg::POS_MIN;
				clock_pkg::POS_MIN: o_pos <= clock_pkg::POS_HR;
				default:            o_pos <= clock_pkg::POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alarm_en <= 1'b0;
		end else if (press.alarm) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	// a held key gives one strobe, nothing more until the next key tick
	a_one_press: assert property (@(posedge clk) disable iff (rst_n == 1'b0)
		(o_evt != '0) |=> (o_evt == '0) until i_key_tick);

endmodule

/* hdl/time_core.sv */
module time_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_sec_tick,
	input  clock_pkg::key_evt_t i_evt,
	input  clock_pkg::mode_e    i_mode,
	input  clock_pkg::pos_e     i_pos,
	input  logic                i_alarm_en,
	output clock_pkg::hms_t     o_shown,
	output logic                o_ring
);

	clock_pkg::hms_t wall;
	clock_pkg::hms_t alarm;

	// +1 with wrap at lim, no carry out
	function automatic clock_pkg::field_t step(
		input clock_pkg::field_t val,
		input clock_pkg::field_t lim
	);
		return (val >= lim) ? '0 : val + 6'd1;
	endfunction

	// ----------------------------------------
	// wall time
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			wall <= '0;
		end else if (i_mode == clock_pkg::MODE_SETUP) begin
			if (i_evt.inc) begin	// frozen, only the selected field moves
				case (i_pos)
					clock_pkg::POS_SEC: wall.sec <= step(wall.sec, clock_pkg::SEC_MAX);
					clock_pkg::POS_MIN: wall.min <= step(wall.min, clock_pkg::MIN_MAX);
					default:            wall.hr  <= step(wall.hr, clock_pkg::HR_MAX);
				endcase
			end
		end else if (i_sec_tick) begin
			wall.sec <= step(wall.sec, clock_pkg::SEC_MAX);
			if (wall.sec == clock_pkg::SEC_MAX) begin
				wall.min <= step(wall.min, clock_pkg::MIN_MAX);
				if (wall.min == clock_pkg::MIN_MAX) begin
					wall.hr <= step(wall.hr, clock_pkg::HR_MAX);
				end
			end
		end
	end

	// ----------------------------------------
	// alarm time
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			alarm <= '0;
		end else if (i_mode == clock_pkg::MODE_ALARM && i_evt.inc) begin
			case (i_pos)
				clock_pkg::POS_SEC: alarm.sec <= step(alarm.sec, clock_pkg::SEC_MAX);
				clock_pkg::POS_MIN: alarm.min <= step(alarm.min, clock_pkg::MIN_MAX);
				default:            alarm.hr  <= step(alarm.hr, clock_pkg::HR_MAX);
			endcase
		end
	end

	assign o_shown = (i_mode == clock_pkg::MODE_ALARM) ? alarm : wall;

	// ring latches on a match and drops once the enable goes away
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_ring <= 1'b0;
		end else if (wall == alarm) begin
			o_ring <= i_alarm_en;
		end else begin
			o_ring <= o_ring & i_alarm_en;
		end
	end

	a_field_range: assert property (@(posedge clk) disable iff (rst_n == 1'b0)
		wall.sec <= clock_pkg::SEC_MAX && wall.min <= clock_pkg::MIN_MAX &&
		wall.hr <= clock_pkg::HR_MAX && alarm.sec <= clock_pkg::SEC_MAX &&
		alarm.min <= clock_pkg::MIN_MAX && alarm.hr <= clock_pkg::HR_MAX);

endmodule

/* hdl/seg_display.sv */
module seg_display (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            i_scan_tick,
	input  logic                            i_blink_tick,
	input  clock_pkg::hms_t                 i_shown,
	input  clock_pkg::mode_e                i_mode,
	input  clock_pkg::pos_e                 i_pos,
	output disp_pkg::seg_t                  o_seg,
	output logic [disp_pkg::NUM_DIGITS-1:0] o_seg_enb
);

	localparam int IW = $clog2(disp_pkg::NUM_DIGITS);
	localparam logic [disp_pkg::NUM_DIGITS-1:0] ENB_ONE = 1;

	clock_pkg::field_t               fld [3];	// sec, min, hr
	logic [3:0]                      digit [disp_pkg::NUM_DIGITS];
	logic [disp_pkg::NUM_DIGITS-1:0] blank;
	logic [IW-1:0]                   scan_idx;
	logic                            blink_off;	// blink phase, 1 = hidden
	logic                            hide;

	// ----------------------------------------
	// digit split and blink mask
	// ----------------------------------------
	assign fld[0] = i_shown.sec;
	assign fld[1] = i_shown.min;
	assign fld[2] = i_shown.hr;

	assign hide = blink_off && (i_mode != clock_pkg::MODE_CLOCK);

	always_comb begin
		for (int f = 0; f < 3; f++) begin
			digit[2*f]     = 4'(fld[f] % 10);	// ones
			digit[2*f + 1] = 4'(fld[f] / 10);	// tens
			blank[2*f]     = hide && (int'(i_pos) == f);
			blank[2*f + 1] = hide && (int'(i_pos) == f);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			blink_off <= 1'b0;
		end else if (i_blink_tick) begin
			blink_off <= ~blink_off;
		end
	end

	// ----------------------------------------
	// scan
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			scan_idx <= '0;
		end else if (i_scan_tick) begin
			if (scan_idx == IW'(disp_pkg::NUM_DIGITS - 1)) begin
				scan_idx <= '0;
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	assign o_seg_enb = ~(ENB_ONE << scan_idx);	// active low common

	assign o_seg = blank[scan_idx] ? disp_pkg::SEG_BLANK :
		disp_pkg::digit_to_seg(digit[scan_idx]);

	// index past the last slot would leave all digits dark
	a_one_digit: assert property (@(posedge clk) disable iff (rst_n == 1'b0)
		$onehot(~o_seg_enb));

endmodule

/* hdl/melody_buzz.sv */
module melody_buzz #(
	parameter int TONE_SHIFT = 3
) (
	input  logic clk,
	input  logic rst_n,
	input  logic i_beat_tick,
	input  logic i_ring,
	output logic o_buzz
);

	// half-periods in clk cycles at 50 MHz
	typedef enum logic [16:0] {
		E4  = 17'd75843,
		F4  = 17'd71587,
		G4  = 17'd63777,
		A4  = 17'd56818,
		B4  = 17'd50619,
		C5  = 17'd47778,
		D5  = 17'd42566,
		E5  = 17'd37922,
		F5  = 17'd35793,
		FS5 = 17'd33785,
		G5  = 17'd31888,
		A5  = 17'd28409,
		B5  = 17'd25310
	} note_e;

	logic [3:0]  beat_idx;
	logic [16:0] half_per;
	logic [16:0] tone_cnt;

	// opening phrase of the melody
	function automatic note_e note_at(input logic [3:0] idx);
		case (idx)
			4'd0:    return E4;
			4'd1:    return A4;
			4'd2:    return C5;
			4'd3,
			4'd4,
			4'd5:    return E5;
			4'd6:    return D5;
			4'd7:    return C5;
			4'd8:    return B4;
			4'd9,
			4'd10,
			4'd11:   return C5;
			4'd12:   return A4;
			4'd13:   return C5;
			4'd14:   return E5;
			default: return A5;
		endcase
	endfunction

	assign half_per = note_at(beat_idx) >> TONE_SHIFT;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			beat_idx <= '0;
			tone_cnt <= '0;
			o_buzz   <= 1'b0;
		end else if (!i_ring) begin	// silent, restart melody next time
			beat_idx <= '0;
			tone_cnt <= '0;
			o_buzz   <= 1'b0;
		end else begin
			if (i_beat_tick) begin
				beat_idx <= beat_idx + 4'd1;	// 16 notes, wraps
			end
			if (tone_cnt + 17'd1 >= half_per) begin
				tone_cnt <= '0;
				o_buzz   <= ~o_buzz;
			end else begin
				tone_cnt <= tone_cnt + 17'd1;
			end
		end
	end

endmodule

/* hdl/clock_top.sv */
module clock_top #(
	parameter int SEC_DIV    = 50_000_000,
	parameter int KEY_DIV    = 500_000,
	parameter int SCAN_DIV   = 2_500,
	parameter int BLINK_DIV  = 12_500_000,
	parameter int BEAT_DIV   = 12_500_000,
	parameter int TONE_SHIFT = 3
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            i_key_mode,
	input  logic                            i_key_pos,
	input  logic                            i_key_inc,
	input  logic                            i_key_alarm,
	output disp_pkg::seg_t                  o_seg,
	output logic [disp_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic                            o_buzz
);

	logic                sec_tick;
	logic                key_tick;
	logic                scan_tick;
	logic                blink_tick;
	logic                beat_tick;
	clock_pkg::key_evt_t evt;
	clock_pkg::mode_e    mode;
	clock_pkg::pos_e     pos;
	logic                alarm_en;
	clock_pkg::hms_t     shown;
	logic                ring;

	// ----------------------------------------
	// strobes
	// ----------------------------------------
	tick_gen #(.DIV(SEC_DIV))   u_sec_tick   (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
	tick_gen #(.DIV(KEY_DIV))   u_key_tick   (.clk(clk), .rst_n(rst_n), .o_tick(key_tick));
	tick_gen #(.DIV(SCAN_DIV))  u_scan_tick  (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
	tick_gen #(.DIV(BLINK_DIV)) u_blink_tick (.clk(clk), .rst_n(rst_n), .o_tick(blink_tick));
	tick_gen #(.DIV(BEAT_DIV))  u_beat_tick  (.clk(clk), .rst_n(rst_n), .o_tick(beat_tick));

	// ----------------------------------------
	// blocks
	// ----------------------------------------
	key_ctrl u_key_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_key_tick  (key_tick),
		.i_key_mode  (i_key_mode),
		.i_key_pos   (i_key_pos),
		.i_key_inc   (i_key_inc),
		.i_key_alarm (i_key_alarm),
		.o_evt       (evt),
		.o_mode      (mode),
		.o_pos       (pos),
		.o_alarm_en  (alarm_en)
	);

	time_core u_time_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sec_tick (sec_tick),
		.i_evt      (evt),
		.i_mode     (mode),
		.i_pos      (pos),
		.i_alarm_en (alarm_en),
		.o_shown    (shown),
		.o_ring     (ring)
	);

	seg_display u_seg_display (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan_tick  (scan_tick),
		.i_blink_tick (blink_tick),
		.i_shown      (shown),
		.i_mode       (mode),
		.i_pos        (pos),
		.o_seg        (o_seg),
		.o_seg_enb    (o_seg_enb)
	);

	melody_buzz #(.TONE_SHIFT(TONE_SHIFT)) u_melody_buzz (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_beat_tick (beat_tick),
		.i_ring      (ring),
		.o_buzz      (o_buzz)
	);

endmodule

/* tests/clock_tasks.svh */
// ----------------------------------------
// helpers
// ----------------------------------------
task automatic check(input int actual, input int expected, input string msg);
	checks++;
	if (actual != expected) begin
		errors++;
		$display("Fail at time %0t: %s, got %0d, expected %0d",
			$time, msg, actual, expected);
	end
endtask

task automatic apply_reset();
	@(posedge clk);
	rst_n <= 1'b0;
	keys  <= '0;
	repeat (10) @(posedge clk);
	rst_n <= 1'b1;
endtask

// returns on the first falling edge with cyc at or past target
task automatic wait_until(input int unsigned target);
	@(negedge clk);
	while (cyc < target) begin
		@(negedge clk);
	end
endtask

task automatic press_key(input clock_pkg::key_evt_t which);
	@(posedge clk);
	keys <= which;
	repeat (3 * KEY_DIV) @(posedge clk);	// three key ticks high
	keys <= '0;
	repeat (3 * KEY_DIV) @(posedge clk);
endtask

function automatic int decode_seg(input disp_pkg::seg_t pat);
	if (pat == disp_pkg::SEG_BLANK) begin
		return 10;
	end
	for (int d = 0; d < 10; d++) begin
		if (pat == disp_pkg::digit_to_seg(4'(d))) begin
			return d;
		end
	end
	return -1;
endfunction

// slots in order 0..5, sampled on the falling edge
task automatic read_display();
	int         n;
	logic [5:0] want;
	for (int k = 0; k < disp_pkg::NUM_DIGITS; k++) begin
		want = ~(6'b00_0001 << k);
		n = 0;
		@(negedge clk);
		while (seg_enb != want && n < 4 * disp_pkg::NUM_DIGITS * SCAN_DIV) begin
			@(negedge clk);
			n++;
		end
		if (seg_enb != want) begin
			errors++;
			$display("digit slot %0d was never enabled, scan enable stuck at %b", k, seg_enb);
		end
		disp_dig[k] = decode_seg(seg);
		if (disp_dig[k] < 0) begin
			errors++;
			$display("digit slot %0d shows pattern %b, which is no digit", k, seg);
		end
	end
endtask

// scan rounds until the blinking pair is lit again
task automatic read_unblanked();
	int tries;
	bit lit;
	tries = 0;
	lit   = 1'b0;
	while (!lit && tries < 8) begin
		read_display();
		lit = 1'b1;
		for (int k = 0; k < disp_pkg::NUM_DIGITS; k++) begin
			if (disp_dig[k] == 10) begin
				lit = 1'b0;
			end
		end
		tries++;
	end
	if (!lit) begin
		errors++;
		$display("display stayed partly blank over %0d scan rounds", tries);
	end
endtask

// 0 sec, 1 min, 2 hr
function automatic int field_val(input int f);
	return disp_dig[2*f + 1] * 10 + disp_dig[2*f];
endfunction

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic verify_reset();
	int buzz_hi;
	buzz_hi = 0;
	apply_reset();
	@(negedge clk);
	check(seg_enb, 6'b11_1110, "scan enable right after reset");
	check(seg, 7'b111_1110, "pattern of digit 0 in slot 0");
	repeat (4 * disp_pkg::NUM_DIGITS * SCAN_DIV) begin
		@(negedge clk);
		if (buzz) begin
			buzz_hi++;
		end
	end
	check(buzz_hi, 0, "buzzer cycles high after reset");
	for (int r = 0; r < 3; r++) begin
		read_display();
		for (int k = 0; k < disp_pkg::NUM_DIGITS; k++) begin
			check(disp_dig[k], 0, $sformatf("slot %0d after reset", k));
		end
	end
endtask

task automatic count_seconds();
	int secs [6] = '{1, 2, 30, 59, 60, 61};	// across the minute carry
	apply_reset();
	foreach (secs[i]) begin
		wait_until(secs[i] * SEC_DIV + SEC_DIV / 2);	// middle of the second
		read_display();
		check(field_val(0), secs[i] % 60, $sformatf("seconds at tick %0d", secs[i]));
		check(field_val(1), secs[i] / 60, $sformatf("minutes at tick %0d", secs[i]));
		check(field_val(2), 0, $sformatf("hours at tick %0d", secs[i]));
	end
endtask

task automatic set_time_fields();
	int k;
	int frozen;
	k = $urandom_range(90, 1);
	apply_reset();
	press_key(KEY_MODE);	// setup
	press_key(KEY_POS);	// minutes
	repeat (k) press_key(KEY_INC);
	read_unblanked();
	check(field_val(1), k % 60, $sformatf("minutes after %0d inc presses", k));
	frozen = field_val(0);
	check(frozen, 0, "seconds when setup was entered");
	wait_until(cyc + 3 * SEC_DIV);
	read_unblanked();
	check(field_val(0), frozen, "seconds after three sec ticks in setup");
	press_key(KEY_POS);	// hours
	repeat (25) press_key(KEY_INC);
	read_unblanked();
	check(field_val(2), 25 % 24, "hours after 25 inc presses");
	check(field_val(1), k % 60, "minutes after stepping hours");
endtask

task automatic blink_selected();
	int hidden;
	int shown;
	int low_blank;
	hidden    = 0;
	shown     = 0;
	low_blank = 0;
	apply_reset();
	press_key(KEY_MODE);
	press_key(KEY_POS);
	press_key(KEY_POS);	// hours selected
	repeat (16) begin	// about four blink phases
		read_display();
		if (disp_dig[4] == 10 && disp_dig[5] == 10) begin
			hidden++;
		end
		if (disp_dig[4] != 10 && disp_dig[5] != 10) begin
			shown++;
		end
		for (int k = 0; k < 4; k++) begin
			if (disp_dig[k] == 10) begin
				low_blank++;
			end
		end
	end
	check(hidden > 0, 1, "scan rounds with hour digits blanked");
	check(shown > 0, 1, "scan rounds with hour digits shown");
	check(low_blank, 0, "blank reads in slots 0 to 3");
endtask

task automatic ring_alarm();
	int unsigned rise_cyc;
	int          toggles;
	int          n;
	logic        last;
	apply_reset();
	press_key(KEY_MODE);
	press_key(KEY_MODE);	// alarm mode, seconds selected
	repeat (5) press_key(KEY_INC);
	read_unblanked();
	check(field_val(0), 5, "alarm seconds shown");
	check(field_val(1), 0, "alarm minutes shown");
	check(field_val(2), 0, "alarm hours shown");
	press_key(KEY_ALARM);	// enable
	press_key(KEY_MODE);	// back to clock
	check(buzz, 0, "buzzer before the alarm time");
	n = 0;
	@(negedge clk);
	while (!buzz && n < 8 * SEC_DIV) begin
		@(negedge clk);
		n++;
	end
	if (!buzz) begin
		errors++;
		$display("buzzer never started after the wall time reached the alarm time");
	end
	rise_cyc = cyc;
	check(rise_cyc >= 5 * SEC_DIV, 1, "buzzer start not before 00:00:05");
	check(rise_cyc < 6 * SEC_DIV, 1, "buzzer start within second 5");
	toggles = 0;
	last    = buzz;
	repeat (200) begin
		@(negedge clk);
		if (buzz != last) begin
			toggles++;
		end
		last = buzz;
	end
	check(toggles >= 4, 1, "buzzer toggling while ringing");
	press_key(KEY_ALARM);	// disable clears the ring
	toggles = 0;
	repeat (200) begin
		@(negedge clk);
		if (buzz) begin
			toggles++;
		end
	end
	check(toggles, 0, "buzzer cycles high after alarm disabled");
endtask

/* tests/tb_clock_top.sv */
module tb_clock_top;

	localparam int CLK_PERIOD = 40;
	localparam int SEC_DIV    = 400;
	localparam int KEY_DIV    = 4;
	localparam int SCAN_DIV   = 2;
	localparam int BLINK_DIV  = 48;
	localparam int BEAT_DIV   = 64;
	localparam int TONE_SHIFT = 12;	// note half-periods down to 6..18 cycles
	localparam int SEED       = 18;

	// run length in sec ticks: reset, count to 61, setup, blink, alarm
	localparam int TEST_SECS   = 1 + 62 + 12 + 2 + 8;
	localparam int MARGIN_SECS = 20;

	localparam clock_pkg::key_evt_t KEY_MODE  = '{mode: 1'b1, default: 1'b0};
	localparam clock_pkg::key_evt_t KEY_POS   = '{pos: 1'b1, default: 1'b0};
	localparam clock_pkg::key_evt_t KEY_INC   = '{inc: 1'b1, default: 1'b0};
	localparam clock_pkg::key_evt_t KEY_ALARM = '{alarm: 1'b1, default: 1'b0};

	logic                            clk;
	logic                            rst_n;
	clock_pkg::key_evt_t             keys;
	disp_pkg::seg_t                  seg;
	logic [disp_pkg::NUM_DIGITS-1:0] seg_enb;
	logic                            buzz;

	int unsigned cyc;	// clk cycles since reset release
	int          checks;
	int          errors;
	int          disp_dig [disp_pkg::NUM_DIGITS];	// 10 = blank, -1 = unknown

	clock_top #(
		.SEC_DIV    (SEC_DIV),
		.KEY_DIV    (KEY_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.BLINK_DIV  (BLINK_DIV),
		.BEAT_DIV   (BEAT_DIV),
		.TONE_SHIFT (TONE_SHIFT)
	) uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_key_mode  (keys.mode),
		.i_key_pos   (keys.pos),
		.i_key_inc   (keys.inc),
		.i_key_alarm (keys.alarm),
		.o_seg       (seg),
		.o_seg_enb   (seg_enb),
		.o_buzz      (buzz)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// same reference point as the DUT tick counters
	always @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	`include "clock_tasks.svh"

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	initial begin
		#((TEST_SECS + MARGIN_SECS) * SEC_DIV * CLK_PERIOD);
		$display("watchdog expired before the test sequence finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		rst_n  = 1'b0;
		keys   = '0;
		checks = 0;
		errors = 0;
		void'($urandom(SEED));
		verify_reset();
		count_seconds();
		set_time_fields();
		blink_selected();
		ring_alarm();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+tests
hdl/clock_pkg.sv
hdl/disp_pkg.sv
hdl/tick_gen.sv
hdl/key_ctrl.sv
hdl/time_core.sv
hdl/seg_display.sv
hdl/melody_buzz.sv
hdl/clock_top.sv
tests/tb_clock_top.sv
